//--- Makefile
# Verilator build and run for the int-to-float converter

VERILATOR ?= verilator
TOP       ?= i2f_conv_tb
FILELIST  ?= i2f_conv.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Test completed successfully

SRCS    := $(shell grep -v '^+' $(FILELIST))
HDRS    := $(wildcard include/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- include/i2f_ref_model.svh
//////////////////////////////
// int-to-float reference model
// expected float bits, round to nearest even
//////////////////////////////

`ifndef I2F_REF_MODEL_SVH
`define I2F_REF_MODEL_SVH

function automatic fpu_types_pkg::float32_t i2f_ref_model(input fpu_types_pkg::int32_t value);
  logic        sign;
  logic [31:0] mag;
  logic [31:0] mant;
  logic [31:0] rem;
  logic [31:0] half;
  int          msb;
  int          sh;
  logic [7:0]  exp;
  sign = value[31];
  // -2^31 keeps its bit pattern as magnitude
  mag  = sign ? (~value + 32'd1) : value;
  if (mag == '0) begin
    return 32'h0000_0000;
  end
  msb = 0;
  for (int i = 0; i < 32; i++) begin
    if (mag[i]) begin
      msb = i;
    end
  end
  if (msb <= 23) begin
    mant = mag << (23 - msb);
  end else begin
    sh   = msb - 23;
    mant = mag >> sh;
    rem  = mag & ((32'd1 << sh) - 32'd1);
    half = 32'd1 << (sh - 1);
    // above half, or a tie with odd mantissa
    if (rem > half || (rem == half && mant[0])) begin
      mant = mant + 32'd1;
    end
    if (mant[24]) begin
      mant = mant >> 1;
      msb  = msb + 1;
    end
  end
  exp = 8'(127 + msb);
  return {sign, exp, mant[22:0]};
endfunction

`endif

//--- bench/i2f_conv_tb.sv
//////////////////////////////
// int-to-float converter testbench
// directed tests against a scoreboard queue
//////////////////////////////

`timescale 1ns/10ps

module i2f_conv_tb;
  import fpu_types_pkg::*;
  import i2f_flow_pkg::*;

  `include "i2f_ref_model.svh"

  localparam int FIFO_DEPTH = DEFAULT_FIFO_DEPTH;
  // cycles any single wait may take
  localparam int TIMEOUT    = 200;

  logic     clk;
  logic     rst;
  logic     flush_i;
  logic     in_valid_i;
  int32_t   in_data_i;
  logic     in_ready_o;
  logic     out_valid_o;
  logic     out_ready_i;
  float32_t out_data_o;

  // expected results, oldest first
  float32_t exp_q [$];
  string    test_name;
  int       errors;
  int       checked;
  integer   seed;
  logic     stalled;
  float32_t stall_data;

  i2f_conv uut (
    .clk         (clk),
    .rst         (rst),
    .flush_i     (flush_i),
    .in_valid_i  (in_valid_i),
    .in_data_i   (in_data_i),
    .in_ready_o  (in_ready_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_data_o  (out_data_o)
  );

  always #10 clk = ~clk;

  //////////////////////////////
  // output monitor
  //////////////////////////////

  // inputs settle 1 ns after the rising edge
  // falling edge sees what the next edge transfers
  always @(negedge clk) begin
    if (rst || flush_i) begin
      stalled = 1'b0;
    end else begin
      // stalled last cycle, result must be unchanged
      if (stalled) begin
        assert (out_data_o == stall_data) else begin
          $display("Error: %s held result, expected %h, actual %h",
                   test_name, stall_data, out_data_o);
          errors++;
        end
      end
      if (out_valid_o && out_ready_i) begin
        assert (exp_q.size() != 0) else begin
          $display("%s: result %h came out with nothing pending", test_name, out_data_o);
          errors++;
        end
        if (exp_q.size() != 0) begin
          assert (out_data_o == exp_q[0]) else begin
            $display("Error: %s, expected %h, actual %h", test_name, exp_q[0], out_data_o);
            errors++;
          end
          void'(exp_q.pop_front());
          checked++;
        end
      end
      stalled    = out_valid_o && !out_ready_i;
      stall_data = out_data_o;
    end
  end

  //////////////////////////////
  // helper tasks
  //////////////////////////////

  // holds the item until accepted, leaves in_valid_i high
  task automatic offer_item(input int32_t value, input float32_t expected);
    int waited;
    waited     = 0;
    in_valid_i = 1'b1;
    in_data_i  = value;
    while (!in_ready_o && waited < TIMEOUT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    assert (in_ready_o) else begin
      $display("%s: input %h was never accepted", test_name, value);
      errors++;
    end
    if (in_ready_o) begin
      exp_q.push_back(expected);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < TIMEOUT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    assert (exp_q.size() == 0) else begin
      $display("%s: %0d results never came out", test_name, exp_q.size());
      errors++;
    end
  endtask

  // hand-worked bit pattern, model cross-checked too
  task automatic convert_known(input int32_t value, input float32_t expected);
    assert (i2f_ref_model(value) == expected) else begin
      $display("Error: %s model for %h, expected %h, actual %h",
               test_name, value, expected, i2f_ref_model(value));
      errors++;
    end
    offer_item(value, expected);
    in_valid_i = 1'b0;
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////

  task automatic test_exact();
    test_name   = "exact";
    out_ready_i = 1'b1;
    convert_known(32'sd0, 32'h0000_0000);
    convert_known(32'sd1, 32'h3F80_0000);
    convert_known(-32'sd1, 32'hBF80_0000);
    convert_known(32'sd8388608, 32'h4B00_0000);
    convert_known(32'sd16777215, 32'h4B7F_FFFF);
    convert_known(32'sd100, 32'h42C8_0000);
    convert_known(-32'sd100, 32'hC2C8_0000);
    wait_drained();
  endtask

  task automatic test_rounding();
    test_name   = "rounding";
    out_ready_i = 1'b1;
    // tie, mantissa stays even
    convert_known(32'sd16777217, 32'h4B80_0000);
    // tie, rounds up to the even mantissa
    convert_known(32'sd16777219, 32'h4B80_0002);
    // mantissa carry into the exponent
    convert_known(32'sh7FFF_FFFF, 32'h4F00_0000);
    convert_known(32'sh8000_0000, 32'hCF00_0000);
    wait_drained();
  endtask

  task automatic test_streaming();
    int32_t value;
    test_name   = "streaming";
    out_ready_i = 1'b1;
    for (int i = 0; i < 200; i++) begin
      value = $random(seed);
      offer_item(value, i2f_ref_model(value));
    end
    in_valid_i = 1'b0;
    wait_drained();
  endtask

  task automatic test_backpressure();
    int32_t value;
    int     accepted;
    logic   take;
    test_name   = "backpressure";
    out_ready_i = 1'b0;
    accepted    = 0;
    value       = $random(seed);
    in_valid_i  = 1'b1;
    in_data_i   = value;
    for (int cyc = 0; cyc < 20; cyc++) begin
      take = in_ready_o;
      if (take) begin
        exp_q.push_back(i2f_ref_model(value));
        accepted++;
      end
      @(posedge clk);
      #1;
      if (take) begin
        value     = $random(seed);
        in_data_i = value;
      end
    end
    in_valid_i = 1'b0;
    // fifo plus producer and consumer registers
    assert (accepted >= FIFO_DEPTH && accepted <= FIFO_DEPTH + 2) else begin
      $display("%s: %0d inputs accepted while stalled", test_name, accepted);
      errors++;
    end
    assert (!in_ready_o && out_valid_o) else begin
      $display("%s: input still ready or no result offered while stalled", test_name);
      errors++;
    end
    out_ready_i = 1'b1;
    wait_drained();
  endtask

  task automatic test_flush();
    int32_t value;
    int     waited;
    test_name   = "flush";
    out_ready_i = 1'b0;
    for (int i = 0; i < 3; i++) begin
      value = 32'sd1000 + i;
      offer_item(value, i2f_ref_model(value));
    end
    in_valid_i = 1'b0;
    // last item still sits in the producer register
    flush_i    = 1'b1;
    @(posedge clk);
    #1;
    flush_i = 1'b0;
    exp_q.delete();
    assert (!out_valid_o) else begin
      $display("%s: result still offered after the flush", test_name);
      errors++;
    end
    // the monitor flags any stale result from here on
    out_ready_i = 1'b1;
    waited      = 0;
    while (!in_ready_o && waited < TIMEOUT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    assert (in_ready_o) else begin
      $display("%s: input side never became ready again", test_name);
      errors++;
    end
    repeat (8) begin
      @(posedge clk);
      #1;
    end
    value = -32'sd12345;
    offer_item(value, i2f_ref_model(value));
    in_valid_i = 1'b0;
    wait_drained();
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    flush_i     = 1'b0;
    in_valid_i  = 1'b0;
    in_data_i   = '0;
    out_ready_i = 1'b1;
    errors      = 0;
    checked     = 0;
    seed        = 28744;
    stalled     = 1'b0;
    stall_data  = '0;
    test_name   = "reset";
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    @(posedge clk);
    #1;
    assert (in_ready_o && !out_valid_o) else begin
      $display("%s: handshake outputs wrong after reset", test_name);
      errors++;
    end
    test_exact();
    test_rounding();
    test_streaming();
    test_backpressure();
    test_flush();
    $display("errors: %0d, results checked: %0d", errors, checked);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- i2f_conv.f
+incdir+include
source/fpu_types_pkg.sv
source/i2f_flow_pkg.sv
source/i2f_stage_if.sv
source/i2f_prenorm.sv
source/i2f_credit_fifo.sv
source/i2f_postnorm.sv
source/i2f_conv.sv
bench/i2f_conv_tb.sv

//--- source/fpu_types_pkg.sv
//////////////////////////////
// fpu number format types
// integer, float, exponent and shift widths
//////////////////////////////

package fpu_types_pkg;

  //////////////////////////////
  // operand and result words
  //////////////////////////////

  // signed integer operand
  typedef logic signed [31:0] int32_t;
  // ieee single, sign / exponent / fraction
  typedef logic [31:0] float32_t;
  // unsigned magnitude of the operand
  typedef logic [31:0] fract32_t;

  //////////////////////////////
  // exponent and shift fields
  //////////////////////////////

  // biased exponent
  typedef logic [7:0] exp8_t;
  // right shift 0..8, leading one down to bit 23
  typedef logic [3:0] shr_t;
  // left shift 0..23, leading one up to bit 23
  typedef logic [4:0] shl_t;

  // bias 127 plus 23 fraction bits
  localparam exp8_t EXP_BIAS_FRACT = 8'd150;

endpackage

//--- source/i2f_conv.sv
//////////////////////////////
// int-to-float converter
// prenorm, credit fifo and postnorm in a row
//////////////////////////////

`timescale 1ns/10ps

module i2f_conv #(
  parameter int FIFO_DEPTH = i2f_flow_pkg::DEFAULT_FIFO_DEPTH
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    flush_i,
  input  logic                    in_valid_i,
  input  fpu_types_pkg::int32_t   in_data_i,
  output logic                    in_ready_o,
  output logic                    out_valid_o,
  input  logic                    out_ready_i,
  output fpu_types_pkg::float32_t out_data_o
);

  // shared link between the three stages
  i2f_stage_if stage_bus ();

  // producer, credits sized to the fifo
  i2f_prenorm #(.FIFO_DEPTH(FIFO_DEPTH)) u_prenorm (
    .clk        (clk),
    .rst        (rst),
    .flush_i    (flush_i),
    .in_valid_i (in_valid_i),
    .in_data_i  (in_data_i),
    .in_ready_o (in_ready_o),
    .stage      (stage_bus)
  );

  // write and read halves on the same link
  i2f_credit_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
    .clk     (clk),
    .rst     (rst),
    .flush_i (flush_i),
    .wr      (stage_bus),
    .rd      (stage_bus)
  );

  i2f_postnorm u_postnorm (
    .clk         (clk),
    .rst         (rst),
    .flush_i     (flush_i),
    .stage       (stage_bus),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_data_o  (out_data_o)
  );

endmodule

//--- source/i2f_credit_fifo.sv
//////////////////////////////
// int-to-float credit fifo
// circular item buffer, one credit back per pop
//////////////////////////////

`timescale 1ns/10ps

module i2f_credit_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        flush_i,
  i2f_stage_if.buffer wr,
  i2f_stage_if.buffer rd
);
  import i2f_flow_pkg::*;

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
  // wrap point, depth need not be a power of two
  localparam logic [PTR_W-1:0] LAST = PTR_W'(FIFO_DEPTH - 1);

  i2f_item_t        mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  //////////////////////////////
  // storage
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (wr.push) begin
      mem[wr_ptr] <= wr.item;
    end
  end

  // head is the oldest entry
  assign rd.head      = mem[rd_ptr];
  assign rd.not_empty = (count != '0);

  //////////////////////////////
  // pointers and occupancy
  //////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      wr.credit_ret <= 1'b0;
    end else if (flush_i) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      wr.credit_ret <= 1'b0;
    end else begin
      if (wr.push) begin
        wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (rd.pop) begin
        rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr.push, rd.pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // slot freed, credit back next cycle
      wr.credit_ret <= rd.pop;
    end
  end

  // producer credits keep the buffer from overflowing
  no_overflow_a: assert property (@(posedge clk) disable iff (rst || flush_i)
    wr.push |-> (count != CNT_W'(FIFO_DEPTH)));

  // consumer only pops a present item
  no_underflow_a: assert property (@(posedge clk) disable iff (rst || flush_i)
    rd.pop |-> rd.not_empty);

endmodule

//--- source/i2f_flow_pkg.sv
//////////////////////////////
// int-to-float flow control
// credit counter and stage item
//////////////////////////////

package i2f_flow_pkg;

  // default buffer depth between the stages
  localparam int DEFAULT_FIFO_DEPTH = 4;

  // credit counter, covers depths up to 8
  typedef logic [3:0] credit_t;

  // one prenormalized item, 66 bits
  typedef struct packed {
    logic                 sign;
    fpu_types_pkg::shr_t  shr;
    fpu_types_pkg::exp8_t exp8shr;
    fpu_types_pkg::shl_t  shl;
    fpu_types_pkg::exp8_t exp8shl;
    fpu_types_pkg::exp8_t exp8sh0;
    fpu_types_pkg::fract32_t fract32;
  } i2f_item_t;

endpackage

//--- source/i2f_postnorm.sv
//////////////////////////////
// int-to-float postnormalization
// shift, round to nearest even, pack
// result held in a valid/ready register
//////////////////////////////

`timescale 1ns/10ps

module i2f_postnorm (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    flush_i,
  i2f_stage_if.cons               stage,
  output logic                    out_valid_o,
  input  logic                    out_ready_i,
  output fpu_types_pkg::float32_t out_data_o
);
  import fpu_types_pkg::*;
  import i2f_flow_pkg::*;

  typedef enum logic {
    RES_EMPTY,
    RES_FULL
  } res_state_e;

  res_state_e  state;
  i2f_item_t   it;
  logic [39:0] shr_wide;
  logic [23:0] mant_r;
  logic        guard;
  logic        sticky;
  logic        round_up;
  logic [24:0] mant_rnd;
  logic [23:0] mant_l;
  exp8_t       exp_res;
  logic [22:0] frac_res;
  float32_t    result;

  assign it = stage.head;

  //////////////////////////////
  // shift and round
  //////////////////////////////

  // leading one lands on bit 31, guard and sticky below bit 8
  assign shr_wide = {it.fract32, 8'd0} >> it.shr;
  assign mant_r   = shr_wide[31:8];
  assign guard    = shr_wide[7];
  assign sticky   = |shr_wide[6:0];
  // ties go to the even mantissa
  assign round_up = guard & (sticky | mant_r[0]);
  assign mant_rnd = {1'b0, mant_r} + 25'(round_up);
  // small values, exact left shift
  assign mant_l   = it.fract32[23:0] << it.shl;

  always_comb begin
    if (it.shr != '0) begin
      if (mant_rnd[24]) begin
        // carry out, mantissa wraps to 1.0
        exp_res  = it.exp8shr + 8'd1;
        frac_res = '0;
      end else begin
        exp_res  = it.exp8shr;
        frac_res = mant_rnd[22:0];
      end
    end else if (it.shl != '0) begin
      exp_res  = it.exp8shl;
      frac_res = mant_l[22:0];
    end else begin
      // bit 23 set, or zero giving +0
      exp_res  = it.exp8sh0;
      frac_res = it.fract32[22:0];
    end
  end

  assign result = {it.sign, exp_res, frac_res};

  //////////////////////////////
  // output register
  //////////////////////////////

  // take a new item when empty or when the current one leaves
  assign stage.pop = stage.not_empty & ~flush_i & ((state == RES_EMPTY) | out_ready_i);
  assign out_valid_o = (state == RES_FULL);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= RES_EMPTY;
    end else if (flush_i) begin
      state <= RES_EMPTY;
    end else if (stage.pop) begin
      state <= RES_FULL;
    end else if (out_ready_i) begin
      state <= RES_EMPTY;
    end
  end

  always_ff @(posedge clk) begin
    if (stage.pop) begin
      out_data_o <= result;
    end
  end

  // stalled result must not change
  hold_stable_a: assert property (@(posedge clk) disable iff (rst || flush_i)
    (out_valid_o && !out_ready_i) |=> $stable(out_data_o));

endmodule

//--- source/i2f_prenorm.sv
//////////////////////////////
// int-to-float prenormalization
// sign, magnitude, shift counts, exponent candidates
// pushes one item per credit
//////////////////////////////

`timescale 1ns/10ps

module i2f_prenorm #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  flush_i,
  input  logic                  in_valid_i,
  input  fpu_types_pkg::int32_t in_data_i,
  output logic                  in_ready_o,
  i2f_stage_if.prod             stage
);
  import fpu_types_pkg::*;
  import i2f_flow_pkg::*;

  logic     sign;
  fract32_t fract32;
  shr_t     shr;
  shl_t     shl;
  credit_t  credits;
  logic     accept;

  //////////////////////////////
  // sign and magnitude
  //////////////////////////////

  assign sign = in_data_i[31];
  // conditional two's complement negate
  assign fract32 = (fract32_t'(in_data_i) ^ {32{sign}}) + fract32_t'(sign);

  // right shift, leading one above bit 23
  always_comb begin
    casez (fract32[31:24])
      8'b1???????: shr = 4'd8;
      8'b01??????: shr = 4'd7;
      8'b001?????: shr = 4'd6;
      8'b0001????: shr = 4'd5;
      8'b00001???: shr = 4'd4;
      8'b000001??: shr = 4'd3;
      8'b0000001?: shr = 4'd2;
      8'b00000001: shr = 4'd1;
      default:     shr = 4'd0;
    endcase
  end

  // left shift, leading one in the low 24 bits
  // highest set bit wins, zero gives 0
  always_comb begin
    shl = 5'd0;
    for (int i = 0; i < 24; i++) begin
      if (fract32[i]) begin
        shl = shl_t'(23 - i);
      end
    end
  end

  //////////////////////////////
  // item register
  //////////////////////////////

  assign in_ready_o = (credits != '0);
  assign accept     = in_valid_i & in_ready_o;

  always_ff @(posedge clk) begin
    if (accept) begin
      stage.item.sign    <= sign;
      stage.item.shr     <= shr;
      stage.item.exp8shr <= EXP_BIAS_FRACT + {4'd0, shr};
      stage.item.shl     <= shl;
      stage.item.exp8shl <= EXP_BIAS_FRACT - {3'd0, shl};
      // hidden one already at bit 23, or zero
      stage.item.exp8sh0 <= {8{fract32[23]}} & EXP_BIAS_FRACT;
      stage.item.fract32 <= fract32;
    end
  end

  // push pulse and credit count
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      stage.push <= 1'b0;
      credits    <= credit_t'(FIFO_DEPTH);
    end else if (flush_i) begin
      stage.push <= 1'b0;
      credits    <= credit_t'(FIFO_DEPTH);
    end else begin
      stage.push <= accept;
      case ({accept, stage.credit_ret})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  // buffer returns no more than was spent
  credit_bound_a: assert property (@(posedge clk) disable iff (rst)
    credits <= credit_t'(FIFO_DEPTH));

endmodule

//--- source/i2f_stage_if.sv
//////////////////////////////
// int-to-float stage link
// item push with credit return, head and pop
//////////////////////////////

`timescale 1ns/10ps

interface i2f_stage_if;
  import i2f_flow_pkg::*;

  //////////////////////////////
  // producer to buffer
  //////////////////////////////

  // one item per pulse, always backed by a credit
  logic      push;
  i2f_item_t item;
  // one credit back per pop, a cycle late
  logic      credit_ret;

  //////////////////////////////
  // buffer to consumer
  //////////////////////////////

  logic      pop;
  // oldest item, valid while not_empty
  i2f_item_t head;
  logic      not_empty;

  modport prod (
    output push, item,
    input  credit_ret
  );

  // fifo side, both write and read halves
  modport buffer (
    input  push, item, pop,
    output credit_ret, head, not_empty
  );

  modport cons (
    input  head, not_empty,
    output pop
  );

endinterface
